//--- rtl/pulse_cfg_pkg.sv
`default_nettype none

package pulse_cfg_pkg;

   localparam int per_w   = 32;                   // frame counter width
   localparam int time_w  = 16;                   // width of the timing fields in the settings
   localparam int att_w   = 7;                    // attenuator word
   localparam int cnt_w   = 8;                    // refocus count and nutation width fields
   localparam logic [per_w-1:0] sync_tail = 10;   // sync outlasts the last pulse by this much
   localparam logic [per_w-1:0] win_guard = 5;    // echo window closes this early

   // 0 refocus pulses is cw, 1 is a hahn echo, more is a cpmg train
   typedef enum logic [1:0] {
      mode_cw,
      mode_hahn,
      mode_cpmg
   } pulse_mode_e;

   // raw settings as the host provides them, all times in clk cycles
   typedef struct packed {
      logic [per_w-1:0]  period;   // frame is period+1 cycles
      logic [time_w-1:0] p1wid;    // pump width
      logic [time_w-1:0] del;      // pump to first refocus gap
      logic [time_w-1:0] p2wid;    // refocus width
      logic [time_w-1:0] p1wid2;   // ch2 first pulse
      logic [time_w-1:0] del2;
      logic [time_w-1:0] p2wid2;   // ch2 second pulse
      logic [time_w-1:0] p1st2;    // ch2 start
      logic [time_w-1:0] nut_d;    // nutation ends this far before frame end
      logic [time_w-1:0] blank;    // window opens this long after a refocus pulse
      logic [cnt_w-1:0]  nut_w;
      logic [cnt_w-1:0]  cp;       // refocus count
      logic [att_w-1:0]  pr_att;
      logic [att_w-1:0]  po_att;
      logic              bl;       // receiver blocking enable
   } pulse_settings_t;

   // decoded frame, absolute counts unless named as a length
   typedef struct packed {
      pulse_mode_e       mode;
      logic [cnt_w-1:0]  refocus;
      logic [per_w-1:0]  period;
      logic [per_w-1:0]  p1_end;       // pump ends here
      logic [per_w-1:0]  ref_start;    // first refocus start
      logic [per_w-1:0]  p2wid;
      logic [per_w-1:0]  echo_sp;      // refocus to refocus spacing
      logic [per_w-1:0]  win_off;      // window open after refocus end
      logic [per_w-1:0]  win_len;      // window close after refocus end
      logic [per_w-1:0]  nut_start;
      logic [per_w-1:0]  nut_stop;
      logic [per_w-1:0]  ch2_start1;
      logic [per_w-1:0]  ch2_stop1;
      logic [per_w-1:0]  ch2_start2;
      logic [per_w-1:0]  ch2_stop2;
   } pulse_cfg_t;

endpackage

`default_nettype wire

//--- rtl/pulse_out_pkg.sv
`default_nettype none

package pulse_out_pkg;

   // where the frame counter sits inside a pulsed frame
   typedef enum logic [2:0] {
      ph_pump,      // pump pulse on
      ph_gap,       // free precession, switch closed
      ph_refocus,   // refocus pulse on
      ph_echo,      // receiver window open
      ph_tail       // after the last window until frame end
   } seq_phase_e;

   // per-cycle gates from the sequencer to the output stage
   typedef struct packed {
      logic pulse;    // pump or refocus
      logic nut;      // nutation pulse
      logic pump;     // pump only, steers the pre attenuator
      logic sync;     // scope and synth strobe
      logic window;   // echo window
      logic ch2;      // second pulse channel
   } pulse_gates_t;

endpackage

`default_nettype wire

//--- rtl/pulse_param_decode.sv
`timescale 1ns/1ns
`default_nettype none

module pulse_param_decode (
   input  logic                                  clk,
   input  logic                                  reset,
   input  pulse_cfg_pkg::pulse_settings_t        settings,
   output pulse_cfg_pkg::pulse_cfg_t             cfg,
   output logic [1:0][pulse_cfg_pkg::att_w-1:0]  att_set,   // [1] pre, [0] post
   output logic                                  block_en
);

   pulse_cfg_pkg::pulse_settings_t       set_q;        // stage 1 copy of the host settings
   pulse_cfg_pkg::pulse_mode_e           mode_d;
   logic [pulse_cfg_pkg::per_w-1:0]      p1;
   logic [pulse_cfg_pkg::per_w-1:0]      dl;
   logic [pulse_cfg_pkg::per_w-1:0]      p2;
   logic [pulse_cfg_pkg::per_w-1:0]      nut_d_ext;
   logic [pulse_cfg_pkg::per_w-1:0]      nut_w_ext;
   logic [pulse_cfg_pkg::per_w-1:0]      ch2_stop1;
   logic [pulse_cfg_pkg::per_w-1:0]      ch2_start2;

   // zero extend a settings time field to counter width
   function automatic logic [pulse_cfg_pkg::per_w-1:0] wide(
      input logic [pulse_cfg_pkg::time_w-1:0] v
   );
      return {{(pulse_cfg_pkg::per_w - pulse_cfg_pkg::time_w){1'b0}}, v};
   endfunction

   always_ff @(posedge clk) begin
      set_q <= settings;   // host holds these steady
   end

   always_comb begin
      case (set_q.cp)
         8'd0:    mode_d = pulse_cfg_pkg::mode_cw;
         8'd1:    mode_d = pulse_cfg_pkg::mode_hahn;
         default: mode_d = pulse_cfg_pkg::mode_cpmg;
      endcase
   end

   assign p1         = wide(set_q.p1wid);
   assign dl         = wide(set_q.del);
   assign p2         = wide(set_q.p2wid);
   assign nut_d_ext  = wide(set_q.nut_d);
   assign nut_w_ext  = wide({{(pulse_cfg_pkg::time_w - pulse_cfg_pkg::cnt_w){1'b0}},
                             set_q.nut_w});
   assign ch2_stop1  = wide(set_q.p1st2) + wide(set_q.p1wid2);
   assign ch2_start2 = ch2_stop1 + wide(set_q.del2);

   // stage 2 precomputes every marker so the sequencer only compares
   always_ff @(posedge clk) begin
      cfg.mode       <= mode_d;
      cfg.refocus    <= set_q.cp;
      cfg.period     <= set_q.period;
      cfg.p1_end     <= p1;
      cfg.ref_start  <= p1 + dl;                          // first pi pulse
      cfg.p2wid      <= p2;
      cfg.echo_sp    <= dl + dl + p2;                     // pi to pi
      cfg.win_off    <= wide(set_q.blank);
      cfg.win_len    <= dl + dl - pulse_cfg_pkg::win_guard;
      cfg.nut_start  <= set_q.period - nut_d_ext - nut_w_ext;
      cfg.nut_stop   <= set_q.period - nut_d_ext;
      cfg.ch2_start1 <= wide(set_q.p1st2);
      cfg.ch2_stop1  <= ch2_stop1;
      cfg.ch2_start2 <= ch2_start2;
      cfg.ch2_stop2  <= ch2_start2 + wide(set_q.p2wid2);
   end

   // attenuator and blocking lines held at 0 in reset so the receiver stays quiet
   always_ff @(posedge clk) begin
      if (!reset) begin
         att_set  <= '0;
         block_en <= 1'b0;
      end else begin
         att_set  <= {set_q.pr_att, set_q.po_att};
         block_en <= set_q.bl;
      end
   end

endmodule

`default_nettype wire

//--- rtl/cpmg_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module cpmg_sequencer (
   input  logic                         clk,
   input  logic                         reset,
   input  pulse_cfg_pkg::pulse_cfg_t    cfg,
   output pulse_out_pkg::pulse_gates_t  gates
);

   logic [pulse_cfg_pkg::per_w-1:0]  cnt;          // frame counter 0..period
   pulse_cfg_pkg::pulse_cfg_t        cfg_q;        // frame config latched at count 0
   pulse_cfg_pkg::pulse_cfg_t        cur;          // config in force this cycle
   logic [pulse_cfg_pkg::cnt_w-1:0]  idx;          // which refocus pulse is next
   pulse_out_pkg::seq_phase_e        phase;
   pulse_out_pkg::seq_phase_e        phase_d;

   // running markers for refocus pulse idx
   logic [pulse_cfg_pkg::per_w-1:0]  nxt_start;
   logic [pulse_cfg_pkg::per_w-1:0]  nxt_end;
   logic [pulse_cfg_pkg::per_w-1:0]  sync_end;     // end + sync_tail
   logic [pulse_cfg_pkg::per_w-1:0]  win_open;
   logic [pulse_cfg_pkg::per_w-1:0]  win_close;
   logic [pulse_cfg_pkg::per_w-1:0]  first_end;

   logic  frame_start;
   logic  pulsed;
   logic  more_ref;       // another refocus pulse follows idx
   logic  advance;
   logic  sync_d;
   logic  nut_d;
   logic  ch2_d;
   logic  sync_q;
   logic  nut_q;
   logic  ch2_q;

   assign frame_start = (cnt == '0);
   assign cur         = frame_start ? cfg : cfg_q;   // new settings only at frame start
   assign pulsed      = (cur.mode != pulse_cfg_pkg::mode_cw);
   assign more_ref    = (idx + 1'b1) < cur.refocus;
   assign first_end   = cfg.ref_start + cfg.p2wid;

   // markers move on once the current echo window has closed
   assign advance = !frame_start && more_ref && (cnt == win_close);

   // the running markers are stale at count 0 so refocus and echo wait a cycle
   always_comb begin
      if (!pulsed)
         phase_d = pulse_out_pkg::ph_pump;            // cw keeps the switch open
      else if (cnt < cur.p1_end)
         phase_d = pulse_out_pkg::ph_pump;
      else if (frame_start)
         phase_d = pulse_out_pkg::ph_gap;
      else if (cnt >= nxt_start && cnt < nxt_end)
         phase_d = pulse_out_pkg::ph_refocus;
      else if (cnt >= win_open && cnt < win_close)
         phase_d = pulse_out_pkg::ph_echo;
      else if (!more_ref && cnt >= win_close)
         phase_d = pulse_out_pkg::ph_tail;            // train finished
      else
         phase_d = pulse_out_pkg::ph_gap;
   end

   always_comb begin
      if (pulsed)
         sync_d = frame_start || more_ref || (cnt < sync_end);
      else
         sync_d = !frame_start && (cnt >= sync_end);  // cw strobe from fixed marker
   end

   assign nut_d = (cnt >= cur.nut_start) && (cnt < cur.nut_stop);
   assign ch2_d = ((cnt >= cur.ch2_start1) && (cnt < cur.ch2_stop1)) ||
                  ((cnt >= cur.ch2_start2) && (cnt < cur.ch2_stop2));

   always_ff @(posedge clk) begin
      if (!reset) begin
         cnt    <= '0;
         idx    <= '0;
         phase  <= pulse_out_pkg::ph_gap;   // all gates low
         sync_q <= 1'b0;
         nut_q  <= 1'b0;
         ch2_q  <= 1'b0;
      end else begin
         cnt <= (cnt < cur.period) ? cnt + 1'b1 : '0;
         if (frame_start)
            idx <= '0;
         else if (advance)
            idx <= idx + 1'b1;
         phase  <= phase_d;
         sync_q <= sync_d;
         nut_q  <= nut_d;
         ch2_q  <= ch2_d;
      end
   end

   always_ff @(posedge clk) begin
      if (frame_start) begin
         cfg_q     <= cfg;
         nxt_start <= cfg.ref_start;
         nxt_end   <= first_end;
         sync_end  <= first_end + pulse_cfg_pkg::sync_tail;
         win_open  <= first_end + cfg.win_off;
         win_close <= first_end + cfg.win_len;
      end else if (advance) begin
         nxt_start <= nxt_start + cfg_q.echo_sp;      // step one echo spacing
         nxt_end   <= nxt_end + cfg_q.echo_sp;
         sync_end  <= sync_end + cfg_q.echo_sp;
         win_open  <= win_open + cfg_q.echo_sp;
         win_close <= win_close + cfg_q.echo_sp;
      end
   end

   always_comb begin
      gates.pulse  = (phase == pulse_out_pkg::ph_pump) ||
                     (phase == pulse_out_pkg::ph_refocus);
      gates.pump   = (phase == pulse_out_pkg::ph_pump);
      gates.window = (phase == pulse_out_pkg::ph_echo);
      gates.nut    = nut_q;
      gates.sync   = sync_q;
      gates.ch2    = ch2_q;
   end

endmodule

`default_nettype wire

//--- rtl/pulse_output_stage.sv
`timescale 1ns/1ns
`default_nettype none

module pulse_output_stage (
   input  logic                                  clk,
   input  logic                                  reset,
   input  pulse_out_pkg::pulse_gates_t           gates,
   input  logic [1:0][pulse_cfg_pkg::att_w-1:0]  att_set,    // [1] pre, [0] post
   input  logic                                  block_en,
   output logic                                  sync_on,
   output logic                                  pulse1_on,
   output logic                                  pulse2_on,
   output logic                                  inhib,
   output logic [pulse_cfg_pkg::att_w-1:0]       pre_att,
   output logic [pulse_cfg_pkg::att_w-1:0]       post_att
);

   logic                              pulse1_d;
   logic                              inhib_d;
   logic [pulse_cfg_pkg::att_w-1:0]   pre_d;
   logic [pulse_cfg_pkg::att_w-1:0]   post_d;

   // main switch carries both the echo train and the nutation pulse
   assign pulse1_d = gates.pulse | gates.nut;

   // pump level only while the pump is on
   assign pre_d = gates.pump ? att_set[1] : '0;

   // receiver path opens fully inside an echo window
   assign post_d  = gates.window ? '0 : att_set[0];
   assign inhib_d = block_en & ~gates.window;

   // last register before the pads
   always_ff @(posedge clk) begin
      if (!reset) begin
         sync_on   <= 1'b0;
         pulse1_on <= 1'b0;
         pulse2_on <= 1'b0;
         inhib     <= 1'b0;
         pre_att   <= '0;
         post_att  <= '0;
      end else begin
         sync_on   <= gates.sync;
         pulse1_on <= pulse1_d;
         pulse2_on <= gates.ch2;      // independent second channel
         inhib     <= inhib_d;
         pre_att   <= pre_d;
         post_att  <= post_d;
      end
   end

endmodule

`default_nettype wire

//--- rtl/pulse_gen_top.sv
`timescale 1ns/1ns
`default_nettype none

module pulse_gen_top (
   input  logic                              clk,
   input  logic                              reset,
   input  pulse_cfg_pkg::pulse_settings_t    settings,
   output logic                              sync_on,
   output logic                              pulse1_on,
   output logic                              pulse2_on,
   output logic                              inhib,
   output logic [pulse_cfg_pkg::att_w-1:0]   pre_att,
   output logic [pulse_cfg_pkg::att_w-1:0]   post_att
);

   pulse_cfg_pkg::pulse_cfg_t                cfg;        // decoded frame markers
   pulse_out_pkg::pulse_gates_t              gates;      // per-cycle gates
   logic [1:0][pulse_cfg_pkg::att_w-1:0]     att_set;
   logic                                     block_en;

   pulse_param_decode u_decode (
      .clk      (clk),
      .reset    (reset),
      .settings (settings),
      .cfg      (cfg),
      .att_set  (att_set),
      .block_en (block_en)
   );

   cpmg_sequencer u_seq (
      .clk   (clk),
      .reset (reset),
      .cfg   (cfg),
      .gates (gates)
   );

   pulse_output_stage u_out (
      .clk       (clk),
      .reset     (reset),
      .gates     (gates),
      .att_set   (att_set),
      .block_en  (block_en),
      .sync_on   (sync_on),
      .pulse1_on (pulse1_on),
      .pulse2_on (pulse2_on),
      .inhib     (inhib),
      .pre_att   (pre_att),
      .post_att  (post_att)
   );

endmodule

`default_nettype wire

//--- dv/pulse_gen_chk.sv
`timescale 1ns/1ns
`default_nettype none

module pulse_gen_chk (
   input  logic                                  clk,
   input  logic                                  reset,
   input  logic                                  sync_on,
   input  logic                                  pulse1_on,
   input  logic                                  pulse2_on,
   input  logic                                  inhib,
   input  logic [pulse_cfg_pkg::att_w-1:0]       pre_att,
   input  logic [pulse_cfg_pkg::att_w-1:0]       post_att,
   input  logic [1:0][pulse_cfg_pkg::att_w-1:0]  att_set    // [1] pre, [0] post
);

   logic quiet;   // every output line inactive

   assign quiet = !sync_on && !pulse1_on && !pulse2_on && !inhib &&
                  (pre_att == '0) && (post_att == '0);

   // receiver blocked, so the post attenuator sits at the host level
   a_inhib_post: assert property (@(posedge clk) disable iff (!reset)
                                  inhib |-> (post_att == $past(att_set[0])))
      else $error("post_att differs from po_att while inhib is high");

   // pre attenuator only moves with the main switch open
   a_pre_pulse: assert property (@(posedge clk) disable iff (!reset)
                                 (pre_att != '0) |-> pulse1_on)
      else $error("pre_att nonzero while pulse1_on is low");

   // outputs held low through reset
   a_reset_quiet: assert property (@(posedge clk) !reset |=> quiet)
      else $error("outputs active while reset is held");

   // and still low on the first cycle out of reset
   a_release_quiet: assert property (@(posedge clk) $rose(reset) |=> quiet)
      else $error("outputs active on the first cycle after reset");

endmodule

bind pulse_gen_top pulse_gen_chk u_chk (
   .clk       (clk),
   .reset     (reset),
   .sync_on   (sync_on),
   .pulse1_on (pulse1_on),
   .pulse2_on (pulse2_on),
   .inhib     (inhib),
   .pre_att   (pre_att),
   .post_att  (post_att),
   .att_set   (att_set)
);

`default_nettype wire

//--- dv/pulse_gen_tb.sv
`timescale 1ns/1ns
`default_nettype none

module pulse_gen_tb;

   // expected top outputs at one counter value
   typedef struct packed {
      logic                             sync;
      logic                             pulse1;
      logic                             pulse2;
      logic                             inhib;
      logic [pulse_cfg_pkg::att_w-1:0]  pre;
      logic [pulse_cfg_pkg::att_w-1:0]  post;
   } out_vec_t;

   logic                             clk;
   logic                             reset;
   pulse_cfg_pkg::pulse_settings_t   settings;
   logic                             sync_on;
   logic                             pulse1_on;
   logic                             pulse2_on;
   logic                             inhib;
   logic [pulse_cfg_pkg::att_w-1:0]  pre_att;
   logic [pulse_cfg_pkg::att_w-1:0]  post_att;

   pulse_cfg_pkg::pulse_settings_t   host_set;      // what the host drives right now
   pulse_cfg_pkg::pulse_settings_t   frame_set;     // settings of the frame on the outputs
   pulse_cfg_pkg::pulse_settings_t   set_list [8];
   int    out_c;          // counter value the outputs show
   logic  checking;
   int    err_count;
   int    check_count;
   int    tests_run;
   int    cycle_count;
   int    cycle_limit;

   pulse_gen_top u_pulse_gen_top (
      .clk       (clk),
      .reset     (reset),
      .settings  (settings),
      .sync_on   (sync_on),
      .pulse1_on (pulse1_on),
      .pulse2_on (pulse2_on),
      .inhib     (inhib),
      .pre_att   (pre_att),
      .post_att  (post_att)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // hard stop sized from the test lengths
   always @(posedge clk) begin
      cycle_count = cycle_count + 1;
      if (cycle_count >= cycle_limit) begin
         $display("timeout: run did not finish within %0d cycles", cycle_limit);
         $display("Regression failed");
         $finish;
      end
   end

   task automatic report_mismatch(input string msg);
      err_count++;
      $display("FAILED %0t ns: %s", $time, msg);
   endtask

   task automatic compare_field(input string name, input int got, input int exp);
      check_count++;
      assert (got == exp)
         else report_mismatch($sformatf("%s is %0d, expected %0d at count %0d",
                                        name, got, exp, out_c));
   endtask

   // frame rules straight from the spec, s_i and end_i per refocus pulse
   function automatic out_vec_t model_outputs(input pulse_cfg_pkg::pulse_settings_t s,
                                              input int c);
      out_vec_t o;
      int    p1;
      int    dl;
      int    p2;
      int    st;
      int    en;
      int    last_end;
      int    i;
      logic  pump;
      logic  refoc;
      logic  window;
      logic  nut;
      logic  ch2;
      logic  sync;
      int    ch2_b;
      p1 = int'(s.p1wid);
      dl = int'(s.del);
      p2 = int'(s.p2wid);
      refoc = 1'b0;
      window = 1'b0;
      last_end = 0;
      if (s.cp == 0) begin
         pump = 1'b1;                                   // cw, switch open all frame
         sync = c >= p1 + dl + p2 + int'(pulse_cfg_pkg::sync_tail);
      end else begin
         pump = c < p1;
         for (i = 0; i < int'(s.cp); i++) begin
            st = p1 + dl + i * (p2 + 2 * dl);
            en = st + p2;
            if (c >= st && c < en)
               refoc = 1'b1;
            if (c >= en + int'(s.blank) && c < en + 2 * dl - int'(pulse_cfg_pkg::win_guard))
               window = 1'b1;
            last_end = en;
         end
         sync = c < last_end + int'(pulse_cfg_pkg::sync_tail);
      end
      nut = (c >= int'(s.period) - int'(s.nut_d) - int'(s.nut_w)) &&
            (c < int'(s.period) - int'(s.nut_d));
      ch2_b = int'(s.p1st2) + int'(s.p1wid2) + int'(s.del2);  // second ch2 pulse start
      ch2 = (c >= int'(s.p1st2) && c < int'(s.p1st2) + int'(s.p1wid2)) ||
            (c >= ch2_b && c < ch2_b + int'(s.p2wid2));
      o.sync   = sync;
      o.pulse1 = pump | refoc | nut;
      o.pulse2 = ch2;
      o.inhib  = s.bl & ~window;
      o.pre    = pump ? s.pr_att : '0;
      o.post   = window ? '0 : s.po_att;
      return o;
   endfunction

   task automatic check_outputs();
      out_vec_t exp;
      exp = model_outputs(frame_set, out_c);
      compare_field("sync_on", sync_on, exp.sync);
      compare_field("pulse1_on", pulse1_on, exp.pulse1);
      compare_field("pulse2_on", pulse2_on, exp.pulse2);
      compare_field("inhib", inhib, exp.inhib);
      compare_field("pre_att", pre_att, exp.pre);
      compare_field("post_att", post_att, exp.post);
   endtask

   // small random timing, period sized so the nutation sits past the last window
   function automatic pulse_cfg_pkg::pulse_settings_t make_settings(input int cp,
                                                                    input logic bl,
                                                                    input logic extras);
      pulse_cfg_pkg::pulse_settings_t s;
      int n;
      s = '0;
      s.p1wid  = 16'($urandom_range(8, 2));
      s.del    = 16'($urandom_range(15, 8));
      s.p2wid  = 16'($urandom_range(6, 2));
      s.blank  = 16'($urandom_range(4, 1));
      s.pr_att = 7'($urandom_range(127, 1));
      s.po_att = 7'($urandom_range(127, 1));
      s.cp     = 8'(cp);
      s.bl     = bl;
      if (extras) begin
         s.p1st2  = 16'd3;
         s.p1wid2 = 16'd5;
         s.del2   = 16'd7;
         s.p2wid2 = 16'd4;
         s.nut_d  = 16'd4;
         s.nut_w  = 8'd6;
      end
      n = (cp == 0) ? 1 : cp;
      s.period = 32'(int'(s.p1wid) + int'(s.del) + n * (int'(s.p2wid) + 2 * int'(s.del)) + 32);
      return s;
   endfunction

   // reset with s1 applied, then 3 frames; s2 lands mid second frame when asked
   task automatic run_test(input string name, input pulse_cfg_pkg::pulse_settings_t s1,
                           input pulse_cfg_pkg::pulse_settings_t s2, input logic change);
      int err_before;
      int frames_done;
      int change_at;
      err_before  = err_count;
      frames_done = 0;
      change_at   = int'(s1.period) / 2;
      checking    = 1'b0;
      @(posedge clk);
      #5;
      reset    = 1'b0;
      settings = s1;
      host_set = s1;
      repeat (2) @(posedge clk);
      #5;
      reset = 1'b1;
      @(posedge clk);                 // sequencer takes the frame start
      @(negedge clk);
      compare_field("outputs after reset",
                    {sync_on, pulse1_on, pulse2_on, inhib, pre_att, post_att}, 0);
      @(posedge clk);
      out_c     = 0;                  // outputs now show count 0
      frame_set = host_set;
      checking  = 1'b1;
      while (frames_done < 3) begin
         @(negedge clk);
         check_outputs();
         @(posedge clk);
         if (out_c == int'(frame_set.period)) begin
            out_c     = 0;
            frame_set = host_set;     // new settings only at a frame start
            frames_done++;
         end else begin
            out_c++;
         end
         #5;
         if (change && frames_done == 1 && out_c == change_at) begin
            settings = s2;
            host_set = s2;
         end
      end
      checking = 1'b0;
      tests_run++;
      $display("test %s done, %0d errors", name, err_count - err_before);
   endtask

   a_block_off: assert property (@(negedge clk) (checking && !frame_set.bl) |-> !inhib)
      else report_mismatch("inhib went high with blocking disabled");

   a_pre_on_pump: assert property (@(negedge clk) (checking && pre_att != '0) |-> pulse1_on)
      else report_mismatch("pre_att nonzero with the main switch closed");

   initial begin
      reset       = 1'b0;
      settings    = '0;
      host_set    = '0;
      frame_set   = '0;
      checking    = 1'b0;
      out_c       = 0;
      err_count   = 0;
      check_count = 0;
      tests_run   = 0;
      cycle_count = 0;
      cycle_limit = 100;
      void'($urandom(32'h79fb));
      set_list[0] = make_settings(0, 1'b0, 1'b0);                          // cw
      set_list[1] = make_settings(1, 1'b1, 1'b0);                          // hahn
      set_list[2] = make_settings(3, 1'b1, 1'b0);
      set_list[3] = make_settings(int'($urandom_range(5, 2)), 1'b1, 1'b0);
      set_list[4] = make_settings(2, 1'b0, 1'b0);                          // blocking off
      set_list[5] = make_settings(2, 1'b1, 1'b1);                          // nutation, ch2
      set_list[6] = make_settings(1, 1'b1, 1'b0);
      set_list[7] = make_settings(2, 1'b1, 1'b1);
      set_list[7].pr_att = set_list[6].pr_att;    // atts and blocking are not frame latched
      set_list[7].po_att = set_list[6].po_att;
      set_list[7].bl     = set_list[6].bl;
      foreach (set_list[i])
         cycle_limit += 3 * (int'(set_list[i].period) + 1) + 8;
      run_test("cw_mode", set_list[0], set_list[0], 1'b0);
      run_test("hahn_echo", set_list[1], set_list[1], 1'b0);
      run_test("cpmg_3", set_list[2], set_list[2], 1'b0);
      run_test("cpmg_random_n", set_list[3], set_list[3], 1'b0);
      run_test("blocking_off", set_list[4], set_list[4], 1'b0);
      run_test("nutation_ch2", set_list[5], set_list[5], 1'b0);
      run_test("mid_frame_change", set_list[6], set_list[7], 1'b1);
      $display("%0d tests, %0d checks, %0d errors", tests_run, check_count, err_count);
      if (err_count == 0)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- pulse_gen_top.f
rtl/pulse_cfg_pkg.sv
rtl/pulse_out_pkg.sv
rtl/pulse_param_decode.sv
rtl/cpmg_sequencer.sv
rtl/pulse_output_stage.sv
rtl/pulse_gen_top.sv
dv/pulse_gen_chk.sv
dv/pulse_gen_tb.sv

//--- Makefile
SIM  := obj_dir/Vpulse_gen_tb
SRCS := $(shell cat pulse_gen_top.f)

all: run

# rebuilt only when a source or the file list changes
$(SIM): pulse_gen_top.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module pulse_gen_tb -f pulse_gen_top.f

# pass or fail comes from the log
run: $(SIM)
	./$(SIM) +verilator+error+limit+1000 | tee sim.log
	grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
